// File: logic/ocl_params.svh
// Width, address-map and register-file depth macros
// for the OCL management path
`ifndef OCL_PARAMS_SVH
`define OCL_PARAMS_SVH

// AXI-Lite bus widths
`define OCL_ADDR_W 32
`define OCL_DATA_W 32
`define OCL_STRB_W 4

// Address bit that picks slot 0 (MMIO) or slot 1 (soft reset)
`define OCL_SLOT_BIT 16

// Register-file depth, word index taken from address bits 3:2
`define OCL_MMIO_WORDS 4

// Only response code the design ever returns
`define OCL_RESP_OKAY 2'd0

`endif

// File: logic/ocl_pkg.sv
// AXI-Lite channel payload structs and the slot request/response
// structs shared by the OCL control path
`default_nettype none

`include "ocl_params.svh"

package ocl_pkg;

  // Basic bus fields
  typedef logic [`OCL_ADDR_W-1:0] axil_addr_t;
  typedef logic [`OCL_DATA_W-1:0] axil_data_t;
  typedef logic [`OCL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]             axil_resp_t;

  // Word index inside the register file
  typedef logic [$clog2(`OCL_MMIO_WORDS)-1:0] slot_offs_t;

  // ------------------------------------------------------------------
  // Channel payloads, valid/ready travel beside them
  // ------------------------------------------------------------------
  typedef struct packed {
    axil_addr_t addr;
  } axil_aw_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_t resp;
  } axil_b_t;

  typedef struct packed {
    axil_addr_t addr;
  } axil_ar_t;

  typedef struct packed {
    axil_data_t data;
    axil_resp_t resp;
  } axil_r_t;

  // ------------------------------------------------------------------
  // Decoder to slot strobes
  // ------------------------------------------------------------------
  typedef struct packed {
    logic       write;
    slot_offs_t offset;
    axil_data_t wdata;
    axil_strb_t strb;
  } slot_req_t;

  typedef struct packed {
    axil_data_t rdata;
  } slot_rsp_t;

endpackage

`default_nettype wire

// File: logic/axil_chan_slice.sv
// Two-entry valid/ready register slice for one AXI-Lite channel
`timescale 1ns/1ns
`default_nettype none

module axil_chan_slice #(
  parameter type payload_t = logic
) (
  input  wire      clk_main_a0,
  input  wire      rst_main_n_sync,
  input  wire      in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  wire      out_ready_i,
  output payload_t out_data_o
);

  // Main stage drives the output, skid stage catches one extra item
  logic     main_valid_q;
  logic     skid_valid_q;
  payload_t main_data_q;
  payload_t skid_data_q;
  logic     accept;
  logic     pop;

  assign accept = in_valid_i && in_ready_o;
  assign pop    = main_valid_q && out_ready_i;

  // Control flags
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (!main_valid_q || pop) begin
      // Main stage frees up, refill from skid first
      main_valid_q <= skid_valid_q || accept;
      skid_valid_q <= 1'b0;
    end else if (accept) begin
      // Main stalled, park the new item
      skid_valid_q <= 1'b1;
    end
  end

  // Payload storage
  always_ff @(posedge clk_main_a0) begin
    if (!main_valid_q || pop) begin
      main_data_q <= skid_valid_q ? skid_data_q : in_data_i;
    end else if (accept) begin
      skid_data_q <= in_data_i;
    end
  end

  // Ready drops only once both entries hold data
  assign in_ready_o  = !skid_valid_q;
  assign out_valid_o = main_valid_q;
  assign out_data_o  = main_data_q;

endmodule

`default_nettype wire

// File: logic/axil_addr_demux.sv
// AXI-Lite to slot decoder, one transaction at a time,
// routed by the slot-select address bit
`timescale 1ns/1ns
`default_nettype none

`include "ocl_params.svh"

module axil_addr_demux import ocl_pkg::*; (
  input  wire       clk_main_a0,
  input  wire       rst_main_n_sync,
  // Write address
  input  wire       aw_valid_i,
  output logic      aw_ready_o,
  input  axil_aw_t  aw_i,
  // Write data
  input  wire       w_valid_i,
  output logic      w_ready_o,
  input  axil_w_t   w_i,
  // Read address
  input  wire       ar_valid_i,
  output logic      ar_ready_o,
  input  axil_ar_t  ar_i,
  // Write response
  output logic      b_valid_o,
  input  wire       b_ready_i,
  output axil_b_t   b_o,
  // Read response
  output logic      r_valid_o,
  input  wire       r_ready_i,
  output axil_r_t   r_o,
  // Slot 0, register file
  output logic      mmio_req_valid_o,
  output slot_req_t mmio_req_o,
  input  wire       mmio_rsp_valid_i,
  input  slot_rsp_t mmio_rsp_i,
  // Slot 1, soft reset
  output logic      rst_req_valid_o,
  output slot_req_t rst_req_o,
  input  wire       rst_rsp_valid_i,
  input  slot_rsp_t rst_rsp_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_HOLD_B, ST_HOLD_R} state_e;

  state_e     state_q;
  logic       wr_go;
  logic       rd_go;
  logic       issue;
  logic       slot_sel;
  logic       slot_q;
  logic       is_write_q;
  logic       rsp_valid;
  axil_addr_t addr;
  slot_req_t  req;
  axil_data_t rdata_q;

  // ------------------------------------------------------------------
  // Pick a transaction, writes win over reads
  // ------------------------------------------------------------------
  assign wr_go = (state_q == ST_IDLE) && aw_valid_i && w_valid_i;
  assign rd_go = (state_q == ST_IDLE) && !wr_go && ar_valid_i;
  assign issue = wr_go || rd_go;

  // AW and W are taken together
  assign aw_ready_o = wr_go;
  assign w_ready_o  = wr_go;
  assign ar_ready_o = rd_go;

  always_comb begin
    addr       = wr_go ? aw_i.addr : ar_i.addr;
    req.write  = wr_go;
    req.offset = slot_offs_t'(addr >> 2);
    req.wdata  = wr_go ? w_i.data : '0;
    req.strb   = wr_go ? w_i.strb : '0;
  end

  // Request goes to exactly one slot
  assign slot_sel         = addr[`OCL_SLOT_BIT];
  assign mmio_req_valid_o = issue && !slot_sel;
  assign rst_req_valid_o  = issue && slot_sel;
  assign mmio_req_o       = req;
  assign rst_req_o        = req;

  // Response strobe of the slot that was addressed
  assign rsp_valid = slot_q ? rst_rsp_valid_i : mmio_rsp_valid_i;

  // ------------------------------------------------------------------
  // Sequencing FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q    <= ST_IDLE;
      slot_q     <= 1'b0;
      is_write_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (issue) begin
            state_q    <= ST_WAIT;
            slot_q     <= slot_sel;
            is_write_q <= wr_go;
          end
        end
        ST_WAIT: begin
          if (rsp_valid) state_q <= is_write_q ? ST_HOLD_B : ST_HOLD_R;
        end
        ST_HOLD_B: if (b_ready_i) state_q <= ST_IDLE;
        ST_HOLD_R: if (r_ready_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Capture read data when the slot answers
  always_ff @(posedge clk_main_a0) begin
    if (state_q == ST_WAIT && rsp_valid) begin
      rdata_q <= slot_q ? rst_rsp_i.rdata : mmio_rsp_i.rdata;
    end
  end

  // Responses held until the slice takes them
  assign b_valid_o = (state_q == ST_HOLD_B);
  assign b_o.resp  = `OCL_RESP_OKAY;
  assign r_valid_o = (state_q == ST_HOLD_R);
  assign r_o.data  = rdata_q;
  assign r_o.resp  = `OCL_RESP_OKAY;

endmodule

`default_nettype wire

// File: logic/soft_rst_slot.sv
// Soft-reset slot: a write gives a one-cycle reset pulse,
// reads return zero
`timescale 1ns/1ns
`default_nettype none

module soft_rst_slot import ocl_pkg::*; (
  input  wire       clk_main_a0,
  input  wire       rst_main_n_sync,
  input  wire       req_valid_i,
  input  slot_req_t req_i,
  output logic      rsp_valid_o,
  output slot_rsp_t rsp_o,
  output logic      soft_rst_o
);

  logic soft_rst_q;
  logic rsp_valid_q;

  // ------------------------------------------------------------------
  // Pulse and response strobe
  // ------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      soft_rst_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Any write fires, the data is ignored
      soft_rst_q  <= req_valid_i && req_i.write;
      // Every request answered one cycle later
      rsp_valid_q <= req_valid_i;
    end
  end

  assign soft_rst_o  = soft_rst_q;
  assign rsp_valid_o = rsp_valid_q;

  // Nothing readable behind this slot
  assign rsp_o.rdata = '0;

endmodule

`default_nettype wire

// File: logic/mmio_regfile.sv
// Small MMIO register file with byte strobes,
// cleared by reset or by the soft-reset pulse
`timescale 1ns/1ns
`default_nettype none

`include "ocl_params.svh"

module mmio_regfile import ocl_pkg::*; (
  input  wire       clk_main_a0,
  input  wire       rst_main_n_sync,
  input  wire       soft_rst_i,
  input  wire       req_valid_i,
  input  slot_req_t req_i,
  output logic      rsp_valid_o,
  output slot_rsp_t rsp_o
);

  axil_data_t words_q [`OCL_MMIO_WORDS];
  logic       rsp_valid_q;
  axil_data_t rdata_q;

  // ------------------------------------------------------------------
  // Storage, byte-merged writes
  // ------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || soft_rst_i) begin
      for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
        words_q[i] <= '0;
      end
    end else if (req_valid_i && req_i.write) begin
      // Only lanes with a strobe bit set change
      for (int b = 0; b < `OCL_STRB_W; b++) begin
        if (req_i.strb[b]) begin
          words_q[req_i.offset][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Response strobe, one cycle after the request
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  // Read data captured with the request
  always_ff @(posedge clk_main_a0) begin
    if (req_valid_i && !req_i.write) begin
      rdata_q <= words_q[req_i.offset];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: logic/cl_ocl_ctrl.sv
// OCL control top: channel slices, address decoder,
// register file and soft-reset slot
`timescale 1ns/1ns
`default_nettype none

module cl_ocl_ctrl import ocl_pkg::*; (
  input  wire      clk_main_a0,
  input  wire      rst_main_n_sync,
  input  axil_aw_t s_aw_i,
  input  wire      s_awvalid_i,
  output logic     s_awready_o,
  input  axil_w_t  s_w_i,
  input  wire      s_wvalid_i,
  output logic     s_wready_o,
  output axil_b_t  s_b_o,
  output logic     s_bvalid_o,
  input  wire      s_bready_i,
  input  axil_ar_t s_ar_i,
  input  wire      s_arvalid_i,
  output logic     s_arready_o,
  output axil_r_t  s_r_o,
  output logic     s_rvalid_o,
  input  wire      s_rready_i,
  output logic     soft_rst_o
);

  // Decoder side of the slices
  axil_aw_t  dm_aw;
  axil_w_t   dm_w;
  axil_ar_t  dm_ar;
  axil_b_t   dm_b;
  axil_r_t   dm_r;
  logic      dm_aw_valid, dm_aw_ready, dm_w_valid, dm_w_ready;
  logic      dm_ar_valid, dm_ar_ready, dm_b_valid, dm_b_ready;
  logic      dm_r_valid, dm_r_ready;
  // Slot strobes
  slot_req_t mmio_req, rst_req;
  slot_rsp_t mmio_rsp, rst_rsp;
  logic      mmio_req_valid, mmio_rsp_valid, rst_req_valid, rst_rsp_valid;

  // ------------------------------------------------------------------
  // Register slices, one per channel
  // ------------------------------------------------------------------
  axil_chan_slice #(.payload_t(axil_aw_t)) aw_slice (.clk_main_a0, .rst_main_n_sync,
    .in_valid_i(s_awvalid_i), .in_ready_o(s_awready_o), .in_data_i(s_aw_i),
    .out_valid_o(dm_aw_valid), .out_ready_i(dm_aw_ready), .out_data_o(dm_aw));

  axil_chan_slice #(.payload_t(axil_w_t)) w_slice (.clk_main_a0, .rst_main_n_sync,
    .in_valid_i(s_wvalid_i), .in_ready_o(s_wready_o), .in_data_i(s_w_i),
    .out_valid_o(dm_w_valid), .out_ready_i(dm_w_ready), .out_data_o(dm_w));

  axil_chan_slice #(.payload_t(axil_ar_t)) ar_slice (.clk_main_a0, .rst_main_n_sync,
    .in_valid_i(s_arvalid_i), .in_ready_o(s_arready_o), .in_data_i(s_ar_i),
    .out_valid_o(dm_ar_valid), .out_ready_i(dm_ar_ready), .out_data_o(dm_ar));

  // Response slices face outward
  axil_chan_slice #(.payload_t(axil_b_t)) b_slice (.clk_main_a0, .rst_main_n_sync,
    .in_valid_i(dm_b_valid), .in_ready_o(dm_b_ready), .in_data_i(dm_b),
    .out_valid_o(s_bvalid_o), .out_ready_i(s_bready_i), .out_data_o(s_b_o));

  axil_chan_slice #(.payload_t(axil_r_t)) r_slice (.clk_main_a0, .rst_main_n_sync,
    .in_valid_i(dm_r_valid), .in_ready_o(dm_r_ready), .in_data_i(dm_r),
    .out_valid_o(s_rvalid_o), .out_ready_i(s_rready_i), .out_data_o(s_r_o));

  // ------------------------------------------------------------------
  // Decoder and its two slots
  // ------------------------------------------------------------------
  axil_addr_demux addr_demux (.clk_main_a0, .rst_main_n_sync,
    .aw_valid_i(dm_aw_valid), .aw_ready_o(dm_aw_ready), .aw_i(dm_aw),
    .w_valid_i(dm_w_valid), .w_ready_o(dm_w_ready), .w_i(dm_w),
    .ar_valid_i(dm_ar_valid), .ar_ready_o(dm_ar_ready), .ar_i(dm_ar),
    .b_valid_o(dm_b_valid), .b_ready_i(dm_b_ready), .b_o(dm_b),
    .r_valid_o(dm_r_valid), .r_ready_i(dm_r_ready), .r_o(dm_r),
    .mmio_req_valid_o(mmio_req_valid), .mmio_req_o(mmio_req),
    .mmio_rsp_valid_i(mmio_rsp_valid), .mmio_rsp_i(mmio_rsp),
    .rst_req_valid_o(rst_req_valid), .rst_req_o(rst_req),
    .rst_rsp_valid_i(rst_rsp_valid), .rst_rsp_i(rst_rsp));

  // Slot 1, its pulse also clears slot 0
  soft_rst_slot rst_slot (.clk_main_a0, .rst_main_n_sync,
    .req_valid_i(rst_req_valid), .req_i(rst_req),
    .rsp_valid_o(rst_rsp_valid), .rsp_o(rst_rsp), .soft_rst_o(soft_rst_o));

  // Slot 0
  mmio_regfile regfile (.clk_main_a0, .rst_main_n_sync, .soft_rst_i(soft_rst_o),
    .req_valid_i(mmio_req_valid), .req_i(mmio_req),
    .rsp_valid_o(mmio_rsp_valid), .rsp_o(mmio_rsp));

endmodule

`default_nettype wire

// File: verif/cl_ocl_ctrl_assert.sv
// Bound checker for the OCL control top: quiet outputs after reset,
// response stability under back-pressure, pulse width, response codes
`timescale 1ns/1ns
`default_nettype none

`include "ocl_params.svh"

module cl_ocl_ctrl_assert import ocl_pkg::*; (
  input wire     clk_main_a0,
  input wire     rst_main_n_sync,
  input wire     awvalid_i,
  input wire     awready_i,
  input wire     arvalid_i,
  input wire     arready_i,
  input wire     bvalid_i,
  input wire     bready_i,
  input axil_b_t b_i,
  input wire     rvalid_i,
  input wire     rready_i,
  input axil_r_t r_i,
  input wire     soft_rst_i
);

  // Count of failed checks
  int   fail_cnt = 0;
  logic addr_seen_q;

  // Set once any AW or AR has been taken since reset
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      addr_seen_q <= 1'b0;
    end else if ((awvalid_i && awready_i) || (arvalid_i && arready_i)) begin
      addr_seen_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Properties
  // ------------------------------------------------------------------
  quiet_after_reset: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !addr_seen_q |-> (!bvalid_i && !rvalid_i && !soft_rst_i))
    else begin fail_cnt++; $error("response or soft reset before any address"); end

  // Stalled responses hold valid and payload
  b_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid_i && !bready_i) |=> (bvalid_i && $stable(b_i)))
    else begin fail_cnt++; $error("write response changed while stalled"); end

  r_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid_i && !rready_i) |=> (rvalid_i && $stable(r_i)))
    else begin fail_cnt++; $error("read response changed while stalled"); end

  pulse_single: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    soft_rst_i |=> !soft_rst_i)
    else begin fail_cnt++; $error("soft reset high for two cycles"); end

  // Only OKAY is ever returned
  bresp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid_i |-> (b_i.resp == `OCL_RESP_OKAY))
    else begin fail_cnt++; $error("bresp is not OKAY"); end

  rresp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid_i |-> (r_i.resp == `OCL_RESP_OKAY))
    else begin fail_cnt++; $error("rresp is not OKAY"); end

endmodule

bind cl_ocl_ctrl cl_ocl_ctrl_assert chk (
  .clk_main_a0, .rst_main_n_sync,
  .awvalid_i(s_awvalid_i), .awready_i(s_awready_o),
  .arvalid_i(s_arvalid_i), .arready_i(s_arready_o),
  .bvalid_i(s_bvalid_o), .bready_i(s_bready_i), .b_i(s_b_o),
  .rvalid_i(s_rvalid_o), .rready_i(s_rready_i), .r_i(s_r_o),
  .soft_rst_i(soft_rst_o)
);

`default_nettype wire

// File: verif/cl_ocl_ctrl_tb.sv
// Testbench for the OCL control top: clock, reset, AXI-Lite stimulus,
// a model of the register file, per-test lines and the verdict
`timescale 1ns/1ns
`default_nettype none

`include "ocl_params.svh"

module cl_ocl_ctrl_tb import ocl_pkg::*; ();

  // Cycles allowed for any single handshake
  localparam int TMO = 200;

  logic       clk_main_a0 = 1'b0;
  logic       rst_main_n_sync;
  axil_aw_t   s_aw;
  axil_w_t    s_w;
  axil_ar_t   s_ar;
  axil_b_t    s_b;
  axil_r_t    s_r;
  logic       s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic       s_arvalid, s_arready, s_rvalid, s_rready, soft_rst;

  // Expected register-file contents
  axil_data_t model [`OCL_MMIO_WORDS];
  int         seed = 22;
  int         errors = 0;
  int         timeouts = 0;
  int         tests = 0;
  int         failed = 0;
  logic       stall = 1'b0;
  int         idx;
  int         op;
  int         pulses;
  int         mark;
  axil_data_t data;
  axil_data_t rd;
  axil_strb_t strb;

  // 8 ns clock
  always #4 clk_main_a0 = ~clk_main_a0;

  cl_ocl_ctrl dut (
    .clk_main_a0, .rst_main_n_sync,
    .s_aw_i(s_aw), .s_awvalid_i(s_awvalid), .s_awready_o(s_awready),
    .s_w_i(s_w), .s_wvalid_i(s_wvalid), .s_wready_o(s_wready),
    .s_b_o(s_b), .s_bvalid_o(s_bvalid), .s_bready_i(s_bready),
    .s_ar_i(s_ar), .s_arvalid_i(s_arvalid), .s_arready_o(s_arready),
    .s_r_o(s_r), .s_rvalid_o(s_rvalid), .s_rready_i(s_rready),
    .soft_rst_o(soft_rst)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  function automatic axil_addr_t word_addr(input int i);
    return axil_addr_t'(i << 2);
  endfunction

  // Byte-lane merge of a write into a model word
  function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t wdata,
                                             input axil_strb_t wstrb);
    axil_data_t res;
    res = old;
    for (int b = 0; b < `OCL_STRB_W; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Everything that went wrong so far, bound checker included
  function automatic int problems();
    return errors + timeouts + dut.chk.fail_cnt;
  endfunction

  task automatic check_value(input string what, input axil_data_t got, input axil_data_t exp);
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TMO);
    timeouts++;
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    if (problems() == start) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed++;
      $display("Test %0d %s: failed", tests, name);
    end
  endtask

  // AW and W together, then B; counts soft-reset pulses seen before bvalid
  task automatic do_write(input axil_addr_t addr, input axil_data_t wdata,
                          input axil_strb_t wstrb, output int npulse);
    int   t;
    logic aw_done;
    logic w_done;
    logic b_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_done  = 1'b0;
    npulse  = 0;
    t       = 0;
    s_aw.addr <= addr;
    s_w.data  <= wdata;
    s_w.strb  <= wstrb;
    s_awvalid <= 1'b1;
    s_wvalid  <= 1'b1;
    while (!(aw_done && w_done) && t < TMO) begin
      @(posedge clk_main_a0);
      t++;
      if (s_awready) aw_done = 1'b1;
      if (s_wready) w_done = 1'b1;
      if (aw_done) s_awvalid <= 1'b0;
      if (w_done) s_wvalid <= 1'b0;
    end
    if (!(aw_done && w_done)) note_timeout("AW/W handshake");
    t = 0;
    while (!b_done && t < TMO) begin
      // Random bready stretches under back-pressure
      s_bready <= stall ? (($random(seed) & 3) == 0) : 1'b1;
      @(posedge clk_main_a0);
      t++;
      if (soft_rst && !s_bvalid) npulse++;
      b_done = s_bvalid && s_bready;
    end
    if (!b_done) note_timeout("write response");
  endtask

  // AR, then R with the read data
  task automatic do_read(input axil_addr_t addr, output axil_data_t rdata);
    int   t;
    logic ar_done;
    logic r_done;
    ar_done = 1'b0;
    r_done  = 1'b0;
    rdata   = '0;
    t       = 0;
    s_ar.addr <= addr;
    s_arvalid <= 1'b1;
    while (!ar_done && t < TMO) begin
      @(posedge clk_main_a0);
      t++;
      ar_done = s_arready;
    end
    s_arvalid <= 1'b0;
    if (!ar_done) note_timeout("AR handshake");
    t = 0;
    while (!r_done && t < TMO) begin
      s_rready <= stall ? (($random(seed) & 3) == 0) : 1'b1;
      @(posedge clk_main_a0);
      t++;
      r_done = s_rvalid && s_rready;
    end
    if (r_done) begin
      rdata = s_r.data;
    end else begin
      note_timeout("read response");
    end
  endtask

  task automatic check_all_words(input string what);
    axil_data_t got;
    for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
      do_read(word_addr(i), got);
      check_value(what, got, model[i]);
    end
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    rst_main_n_sync <= 1'b0;
    s_aw      <= '0;
    s_w       <= '0;
    s_ar      <= '0;
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    s_arvalid <= 1'b0;
    s_bready  <= 1'b0;
    s_rready  <= 1'b0;
    for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    @(posedge clk_main_a0);

    // Quiet outputs and an all-zero register file
    mark = problems();
    check_value("bvalid, rvalid, soft reset", {29'd0, s_bvalid, s_rvalid, soft_rst}, '0);
    check_all_words("word after reset");
    finish_test("reset state", mark);

    // Full-word writes
    mark = problems();
    for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
      data = $random(seed);
      do_write(word_addr(i), data, 4'hf, pulses);
      check_value("pulses on register write", pulses, 0);
      model[i] = data;
    end
    check_all_words("full-word readback");
    finish_test("full-word write", mark);

    // Random byte strobes
    mark = problems();
    repeat (12) begin
      idx  = $random(seed) & 3;
      data = $random(seed);
      strb = axil_strb_t'($random(seed));
      do_write(word_addr(idx), data, strb, pulses);
      model[idx] = merge_bytes(model[idx], data, strb);
    end
    check_all_words("strobed readback");
    finish_test("partial strobes", mark);

    // Write to slot 1 clears the register file
    mark = problems();
    do_write(axil_addr_t'(1) << `OCL_SLOT_BIT, $random(seed), 4'hf, pulses);
    check_value("soft-reset pulses", pulses, 1);
    for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
      model[i] = '0;
    end
    check_all_words("word after soft reset");
    // Nonzero MMIO read data left behind so a misrouted slot 1 read shows up
    data = $random(seed) | 32'h1;
    do_write(word_addr(0), data, 4'hf, pulses);
    model[0] = data;
    do_read(word_addr(0), rd);
    check_value("word before slot read", rd, model[0]);
    do_read(axil_addr_t'(1) << `OCL_SLOT_BIT, rd);
    check_value("soft-reset slot read", rd, '0);
    finish_test("soft reset", mark);

    // Mixed traffic with bready and rready stalls
    mark = problems();
    stall = 1'b1;
    repeat (40) begin
      op  = $random(seed) & 7;
      idx = $random(seed) & 3;
      if (op == 0) begin
        do_write(axil_addr_t'(1) << `OCL_SLOT_BIT, $random(seed), 4'hf, pulses);
        check_value("soft-reset pulses", pulses, 1);
        for (int i = 0; i < `OCL_MMIO_WORDS; i++) begin
          model[i] = '0;
        end
      end else if (op < 4) begin
        data = $random(seed);
        strb = axil_strb_t'($random(seed));
        do_write(word_addr(idx), data, strb, pulses);
        model[idx] = merge_bytes(model[idx], data, strb);
      end else begin
        do_read(word_addr(idx), rd);
        check_value("read under back-pressure", rd, model[idx]);
      end
    end
    check_all_words("word after mixed traffic");
    stall = 1'b0;
    finish_test("back-pressure", mark);

    $display("%0d tests, %0d failed, %0d errors, %0d timeouts, %0d assertion failures",
             tests, failed, errors, timeouts, dut.chk.fail_cnt);
    if (failed == 0 && problems() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cl_ocl_ctrl.f
+incdir+logic
logic/ocl_pkg.sv
logic/axil_chan_slice.sv
logic/axil_addr_demux.sv
logic/soft_rst_slot.sv
logic/mmio_regfile.sv
logic/cl_ocl_ctrl.sv
verif/cl_ocl_ctrl_assert.sv
verif/cl_ocl_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the OCL control testbench with Verilator and run it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cl_ocl_ctrl_tb \
  -f cl_ocl_ctrl.f \
  -o cl_ocl_ctrl_sim

# Keep running after an assertion error so the testbench reaches its verdict
./obj_dir/cl_ocl_ctrl_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
grep -q "Simulation PASSED" sim.log
